/* common/load_pkg.sv */
// ----------------------------------------------------------------------
// shared widths, types and port structs of the load unit
// imported by every RTL module of the load path
// ----------------------------------------------------------------------
package load_pkg;

  // ----------------------------------------------------------------------
  // widths
  // ----------------------------------------------------------------------
  localparam int unsigned XLEN       = 64;
  localparam int unsigned ADDR_W     = 32;
  // cache index covers exactly the page offset
  localparam int unsigned INDEX_W    = 12;
  localparam int unsigned TAG_W      = ADDR_W - INDEX_W;
  localparam int unsigned TRANS_ID_W = 3;
  // outstanding loads, one cache id per slot
  localparam int unsigned NR_LDBUF   = 4;
  localparam int unsigned LDBUF_ID_W = 2;
  // byte position inside a doubleword
  localparam int unsigned OFFSET_W   = 3;

  // ----------------------------------------------------------------------
  // plain vector types
  // ----------------------------------------------------------------------
  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [INDEX_W-1:0]    index_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [TRANS_ID_W-1:0] trans_id_t;
  typedef logic [LDBUF_ID_W-1:0] ldbuf_id_t;
  typedef logic [OFFSET_W-1:0]   offset_t;
  // one enable bit per byte of a doubleword
  typedef logic [XLEN/8-1:0]     be_t;

  // integer loads, signed and unsigned variants
  typedef enum logic [2:0] {LD, LW, LWU, LH, LHU, LB, LBU} load_op_e;

  // request from issue, held until popped
  typedef struct packed {
    load_op_e  op;
    addr_t     addr;
    trans_id_t trans_id;
  } load_req_t;

  // what must survive until the response comes back
  typedef struct packed {
    trans_id_t trans_id;
    offset_t   offset;
    load_op_e  op;
  } ldbuf_entry_t;

  // unit to data cache
  typedef struct packed {
    logic      data_req;
    index_t    index;
    be_t       be;
    logic [1:0] size;
    ldbuf_id_t id;
    logic      tag_valid;
    tag_t      tag;
    logic      kill;
  } dcache_req_t;

  // data cache to unit
  typedef struct packed {
    logic      gnt;
    logic      rvalid;
    ldbuf_id_t rid;
    xlen_t     rdata;
  } dcache_rsp_t;

endpackage

/* load_buffer/load_buffer.sv */
// ----------------------------------------------------------------------
// tracks outstanding loads by cache id until their response returns
// written on grant, read and freed on rvalid, marked on flush
// ----------------------------------------------------------------------
module load_buffer
  import load_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         flush_i,
  // new outstanding load, goes to the free slot
  input  logic         write_i,
  input  ldbuf_entry_t write_entry_i,
  // response side, frees the slot at read_id_i
  input  logic         read_i,
  input  ldbuf_id_t    read_id_i,
  output logic         full_o,
  output ldbuf_id_t    free_id_o,
  output ldbuf_entry_t read_entry_o,
  output logic         read_live_o
);

  // ----------------------------------------------------------------------
  // storage
  // ----------------------------------------------------------------------
  logic [NR_LDBUF-1:0] valid_d, valid_q;
  logic [NR_LDBUF-1:0] flushed_d, flushed_q;
  // payload, only meaningful while the valid bit is set
  ldbuf_entry_t        entries_q [NR_LDBUF];

  ldbuf_id_t           free_id;

  // ----------------------------------------------------------------------
  // free slot search
  // ----------------------------------------------------------------------
  // lowest clear valid bit wins
  always_comb begin
    free_id = '0;
    for (int i = NR_LDBUF - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_id = ldbuf_id_t'(i);
      end
    end
  end

  assign free_id_o = free_id;
  assign full_o    = &valid_q;

  // ----------------------------------------------------------------------
  // valid and flushed bookkeeping
  // ----------------------------------------------------------------------
  always_comb begin
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // everything in flight becomes stale
    if (flush_i) begin
      flushed_d = flushed_q | valid_q;
    end
    // response retires its slot
    if (read_i) begin
      valid_d[read_id_i] = 1'b0;
    end
    // new load starts clean
    if (write_i) begin
      valid_d[free_id]   = 1'b1;
      flushed_d[free_id] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
    end
  end

  // payload write, slot chosen by the search above
  always_ff @(posedge clk_i) begin
    if (write_i) begin
      entries_q[free_id] <= write_entry_i;
    end
  end

  // ----------------------------------------------------------------------
  // read port
  // ----------------------------------------------------------------------
  // combinational so rvalid reaches valid_o in the same cycle
  assign read_entry_o = entries_q[read_id_i];

  // stale or flushed in this very cycle retires silently
  assign read_live_o = read_i && valid_q[read_id_i] && !flushed_q[read_id_i] && !flush_i;

  // ----------------------------------------------------------------------
  // assertions
  // ----------------------------------------------------------------------
  // the controller must hold off issue while every slot is taken
  a_no_write_when_full : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    write_i |-> !full_o
  ) else $error("load buffer written while full");

  // the cache may only answer ids that are outstanding
  a_read_valid_slot : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    read_i |-> valid_q[read_id_i]
  ) else $error("response for a load buffer slot that is not in use");

endmodule

/* logic/load_ctrl.sv */
// ----------------------------------------------------------------------
// request side FSM of the load unit
// sends index, waits for grant, sends tag next cycle, kills on flush
// ----------------------------------------------------------------------
module load_ctrl
  import load_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_i,
  // issue handshake
  input  logic        valid_i,
  input  load_req_t   load_req_i,
  // store buffer reports a pending store to the same page offset
  input  logic        page_offset_match_i,
  // load buffer status
  input  logic        ldbuf_full_i,
  input  ldbuf_id_t   ldbuf_free_id_i,
  input  logic        gnt_i,
  output logic        ldbuf_write_o,
  output logic        pop_o,
  output dcache_req_t dcache_req_o
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    SEND_TAG,
    WAIT_PAGE_OFFSET,
    WAIT_FLUSH
  } state_e;

  state_e     state_d, state_q;

  offset_t    req_offset;
  logic       accept;
  logic       granted;
  logic       data_req;
  logic       tag_valid;
  logic       kill;
  be_t        be;
  logic [1:0] size;
  // tag of the granted request, sent in the following cycle
  tag_t       tag_q;

  assign req_offset = load_req_i.addr[OFFSET_W-1:0];
  // a slot must be free before the cache sees the request
  assign accept     = valid_i && !ldbuf_full_i;
  assign granted    = data_req && gnt_i;
  // a grant in the flush cycle is killed next cycle, nothing to track
  assign ldbuf_write_o = granted && !flush_i;

  // ----------------------------------------------------------------------
  // byte enables and transfer size
  // ----------------------------------------------------------------------
  always_comb begin
    unique case (load_req_i.op)
      LW, LWU: begin
        size = 2'b10;
        be   = be_t'(8'h0f) << req_offset;
      end
      LH, LHU: begin
        size = 2'b01;
        be   = be_t'(8'h03) << req_offset;
      end
      LB, LBU: begin
        size = 2'b00;
        be   = be_t'(8'h01) << req_offset;
      end
      default: begin
        // doubleword
        size = 2'b11;
        be   = '1;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // request FSM
  // ----------------------------------------------------------------------
  always_comb begin
    state_d   = state_q;
    data_req  = 1'b0;
    tag_valid = 1'b0;
    kill      = 1'b0;
    pop_o     = 1'b0;

    unique case (state_q)
      // SEND_TAG overlaps the tag of the last load with a new index
      IDLE, SEND_TAG: begin
        if (state_q == SEND_TAG) begin
          tag_valid = 1'b1;
          state_d   = IDLE;
        end
        if (accept) begin
          if (page_offset_match_i) begin
            // let the store drain first
            state_d = WAIT_PAGE_OFFSET;
          end else begin
            data_req = 1'b1;
            if (gnt_i) begin
              state_d = SEND_TAG;
              pop_o   = 1'b1;
            end else begin
              state_d = WAIT_GNT;
            end
          end
        end
      end

      WAIT_PAGE_OFFSET: begin
        if (!page_offset_match_i) begin
          state_d = WAIT_GNT;
        end
      end

      // request stays up until the cache takes it
      WAIT_GNT: begin
        data_req = 1'b1;
        if (gnt_i) begin
          state_d = SEND_TAG;
          pop_o   = 1'b1;
        end
      end

      // abort whatever was granted in the flush cycle
      WAIT_FLUSH: begin
        kill      = 1'b1;
        tag_valid = 1'b1;
        state_d   = IDLE;
      end

      default: state_d = IDLE;
    endcase

    // flush wins over everything, the killed request is not popped
    if (flush_i) begin
      state_d = WAIT_FLUSH;
      pop_o   = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // capture tag on grant, also for a request that gets killed
  always_ff @(posedge clk_i) begin
    if (granted) begin
      tag_q <= load_req_i.addr[ADDR_W-1:INDEX_W];
    end
  end

  assign dcache_req_o = '{
    data_req:  data_req,
    index:     load_req_i.addr[INDEX_W-1:0],
    be:        be,
    size:      size,
    id:        ldbuf_free_id_i,
    tag_valid: tag_valid,
    tag:       tag_q,
    kill:      kill
  };

  // ----------------------------------------------------------------------
  // assertions
  // ----------------------------------------------------------------------
  // issue only sends naturally aligned loads, the aligner relies on it
  a_word_offset : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (granted && (load_req_i.op inside {LW, LWU})) |-> (req_offset < 5)
  ) else $error("misaligned word load granted");

  a_half_offset : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (granted && (load_req_i.op inside {LH, LHU})) |-> (req_offset < 7)
  ) else $error("misaligned halfword load granted");

endmodule

/* logic/load_align.sv */
// ----------------------------------------------------------------------
// realigns load data by the stored byte offset and extends it
// purely combinational, sits between the cache response and result_o
// ----------------------------------------------------------------------
module load_align
  import load_pkg::*;
(
  input  ldbuf_entry_t entry_i,
  input  xlen_t        rdata_i,
  output xlen_t        result_o
);

  xlen_t                shifted;
  logic [XLEN/8-1:0]    sign_bits;
  offset_t              sign_offset;
  logic                 is_signed;
  logic                 sign_bit;

  // ----------------------------------------------------------------------
  // shift path
  // ----------------------------------------------------------------------
  // addressed byte moves down to bit 0
  assign shifted = rdata_i >> {entry_i.offset, 3'b000};

  // ----------------------------------------------------------------------
  // sign path, runs beside the shifter
  // ----------------------------------------------------------------------
  // top bit of every byte, one of them is the sign
  for (genvar i = 0; i < XLEN/8; i++) begin : gen_sign_bits
    assign sign_bits[i] = rdata_i[(i+1)*8-1];
  end

  assign is_signed = entry_i.op inside {LW, LH, LB};

  // byte that holds the most significant bit of the loaded value
  always_comb begin
    unique case (entry_i.op)
      LW, LWU: sign_offset = entry_i.offset + offset_t'(3);
      LH, LHU: sign_offset = entry_i.offset + offset_t'(1);
      default: sign_offset = entry_i.offset;
    endcase
  end

  // unsigned loads pull it to zero
  assign sign_bit = is_signed & sign_bits[sign_offset];

  // ----------------------------------------------------------------------
  // result mux
  // ----------------------------------------------------------------------
  always_comb begin
    unique case (entry_i.op)
      LW, LWU: begin
        result_o = {{(XLEN-32){sign_bit}}, shifted[31:0]};
      end
      LH, LHU: begin
        result_o = {{(XLEN-16){sign_bit}}, shifted[15:0]};
      end
      LB, LBU: begin
        result_o = {{(XLEN-8){sign_bit}}, shifted[7:0]};
      end
      default: begin
        // LD, offset is always zero here
        result_o = shifted;
      end
    endcase
  end

endmodule

/* logic/load_unit.sv */
// ----------------------------------------------------------------------
// load unit top, connects issue, data cache and store buffer ports
// to the request FSM, the outstanding load buffer and the aligner
// ----------------------------------------------------------------------
module load_unit
  import load_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_i,
  // issue side
  input  logic        valid_i,
  input  load_req_t   load_req_i,
  output logic        pop_o,
  // store buffer address check
  output index_t      page_offset_o,
  input  logic        page_offset_match_i,
  // data cache
  output dcache_req_t dcache_req_o,
  input  dcache_rsp_t dcache_rsp_i,
  // writeback, no back-pressure
  output logic        valid_o,
  output trans_id_t   trans_id_o,
  output xlen_t       result_o
);

  logic         ldbuf_write;
  logic         ldbuf_full;
  ldbuf_id_t    ldbuf_free_id;
  ldbuf_entry_t ldbuf_write_entry;
  ldbuf_entry_t ldbuf_read_entry;

  // store buffer compares on the untranslated low bits
  assign page_offset_o = load_req_i.addr[INDEX_W-1:0];

  assign ldbuf_write_entry = '{
    trans_id: load_req_i.trans_id,
    offset:   load_req_i.addr[OFFSET_W-1:0],
    op:       load_req_i.op
  };

  load_ctrl load_ctrl_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (flush_i),
    .valid_i             (valid_i),
    .load_req_i          (load_req_i),
    .page_offset_match_i (page_offset_match_i),
    .ldbuf_full_i        (ldbuf_full),
    .ldbuf_free_id_i     (ldbuf_free_id),
    .gnt_i               (dcache_rsp_i.gnt),
    .ldbuf_write_o       (ldbuf_write),
    .pop_o               (pop_o),
    .dcache_req_o        (dcache_req_o)
  );

  // cache rid indexes the buffer directly
  load_buffer load_buffer_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .write_i       (ldbuf_write),
    .write_entry_i (ldbuf_write_entry),
    .read_i        (dcache_rsp_i.rvalid),
    .read_id_i     (dcache_rsp_i.rid),
    .full_o        (ldbuf_full),
    .free_id_o     (ldbuf_free_id),
    .read_entry_o  (ldbuf_read_entry),
    .read_live_o   (valid_o)
  );

  assign trans_id_o = ldbuf_read_entry.trans_id;

  load_align load_align_inst (
    .entry_i  (ldbuf_read_entry),
    .rdata_i  (dcache_rsp_i.rdata),
    .result_o (result_o)
  );

endmodule

/* tests/dcache_model.sv */
// ----------------------------------------------------------------------
// behavioural data cache for the load unit testbench
// random grants, responses 1 to 6 cycles after the tag, any order
// ----------------------------------------------------------------------
module dcache_model
  import load_pkg::*;
#(
  parameter int unsigned SEED = 0
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  dcache_req_t req_i,
  output dcache_rsp_t rsp_o
);

  integer              seed = integer'(SEED);
  // loads waiting for their response, one per cache id
  logic [NR_LDBUF-1:0] pend_valid;
  int                  pend_delay [NR_LDBUF];
  index_t              pend_index [NR_LDBUF];
  // grant of the previous cycle, its tag arrives now
  logic                last_valid;
  ldbuf_id_t           last_id;
  index_t              last_index;

  // byte at address a holds the low byte of a xor 5a
  function automatic xlen_t line_data(index_t index);
    xlen_t data;
    for (int k = 0; k < 8; k++) begin
      data[k*8 +: 8] = {index[7:3], 3'(k)} ^ 8'h5a;
    end
    return data;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    int        r;
    int        start;
    int        j;
    logic      found;
    ldbuf_id_t pick;
    if (!rst_ni) begin
      rsp_o      <= '0;
      pend_valid = '0;
      last_valid = 1'b0;
    end else begin
      r = $random(seed);
      // killed requests never answer
      if (last_valid && req_i.tag_valid && !req_i.kill) begin
        pend_valid[last_id] = 1'b1;
        pend_delay[last_id] = 1 + int'($unsigned(r) % 6);
        pend_index[last_id] = last_index;
      end
      last_valid = req_i.data_req && rsp_o.gnt;
      last_id    = req_i.id;
      last_index = req_i.index;
      for (int i = 0; i < NR_LDBUF; i++) begin
        if (pend_valid[i] && pend_delay[i] > 0) begin
          pend_delay[i]--;
        end
      end
      // random start of the scan gives out-of-order answers
      found = 1'b0;
      pick  = '0;
      start = (r >> 8) & 3;
      for (int i = 0; i < NR_LDBUF; i++) begin
        j = (start + i) % NR_LDBUF;
        if (!found && pend_valid[j] && pend_delay[j] == 0) begin
          found = 1'b1;
          pick  = ldbuf_id_t'(j);
        end
      end
      if (found) begin
        pend_valid[pick] = 1'b0;
      end
      rsp_o <= '{gnt:    r[16] | r[17],
                 rvalid: found,
                 rid:    pick,
                 rdata:  found ? line_data(pend_index[pick]) : '0};
    end
  end

endmodule

/* tests/load_unit_tb.sv */
// ----------------------------------------------------------------------
// testbench of the load unit, random loads against a cache model
// checks results, ids, tag timing, stalls and flush behaviour
// ----------------------------------------------------------------------
module load_unit_tb
  import load_pkg::*;
;

  localparam int NR_REQ     = 200;
  localparam int CLK_PERIOD = 4;
  localparam int NR_TESTS   = 3;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        flush_i;
  logic        valid_i;
  load_req_t   load_req_i;
  logic        pop_o;
  index_t      page_offset_o;
  logic        page_offset_match_i;
  dcache_req_t dcache_req;
  dcache_rsp_t dcache_rsp;
  logic        valid_o;
  trans_id_t   trans_id_o;
  xlen_t       result_o;

  integer      seed = 32'hb36a_958c;
  int          errors = 0;
  int          test_start;
  int          outstanding = 0;
  // scoreboard keyed by trans_id
  logic [7:0]  exp_valid = '0;
  xlen_t       exp_result [8];
  logic        match_en = 1'b0;
  logic        flush_en = 1'b0;
  // previous cycle, for tag and kill timing
  logic        prev_grant = 1'b0;
  logic        prev_flush = 1'b0;
  logic        prev_match = 1'b0;
  logic        prev_wait = 1'b0;
  tag_t        prev_tag;

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  load_unit load_unit_inst (
    .clk_i, .rst_ni, .flush_i, .valid_i, .load_req_i, .pop_o, .page_offset_o,
    .page_offset_match_i, .dcache_req_o(dcache_req), .dcache_rsp_i(dcache_rsp),
    .valid_o, .trans_id_o, .result_o
  );

  dcache_model #(.SEED(32'hb36a_958c)) dcache_model_inst (
    .clk_i, .rst_ni, .req_i(dcache_req), .rsp_o(dcache_rsp)
  );

  // log2 of the access width in bytes
  function automatic int size_log2(load_op_e op);
    case (op)
      LD:      return 3;
      LW, LWU: return 2;
      LH, LHU: return 1;
      default: return 0;
    endcase
  endfunction

  // expected result from the cache data rule, shifted and extended
  function automatic xlen_t expected_result(load_op_e op, addr_t addr);
    logic [7:0] bytes [8];
    int         nbytes;
    xlen_t      value;
    logic       sgn;
    for (int k = 0; k < 8; k++) begin
      bytes[k] = {addr[7:3], 3'(k)} ^ 8'h5a;
    end
    nbytes = 1 << size_log2(op);
    value = '0;
    for (int k = 0; k < nbytes; k++) begin
      value[k*8 +: 8] = bytes[int'(addr[2:0]) + k];
    end
    sgn = (op inside {LW, LH, LB}) && bytes[int'(addr[2:0]) + nbytes - 1][7];
    for (int b = nbytes * 8; b < XLEN; b++) begin
      value[b] = sgn;
    end
    return value;
  endfunction

  // one request held on the issue side until popped
  task automatic issue_request();
    load_op_e  op;
    addr_t     addr;
    trans_id_t tid;
    op   = load_op_e'($unsigned($random(seed)) % 7);
    addr = addr_t'($random(seed));
    case (op)
      LD:      addr[2:0] = 3'b000;
      LW, LWU: addr[1:0] = 2'b00;
      LH, LHU: addr[0]   = 1'b0;
      default: ;
    endcase
    tid = trans_id_t'($random(seed));
    @(posedge clk_i);
    // skip ids still waiting for their result
    while (exp_valid[tid]) begin
      tid = tid + 1'b1;
    end
    valid_i    <= 1'b1;
    load_req_i <= '{op: op, addr: addr, trans_id: tid};
    do @(negedge clk_i); while (!pop_o);
  endtask

  // wait until every load has returned
  task automatic drain();
    do @(posedge clk_i); while (exp_valid != 0 || outstanding != 0);
    @(negedge clk_i);
  endtask

  initial begin
    rst_ni              = 1'b0;
    flush_i             = 1'b0;
    valid_i             = 1'b0;
    page_offset_match_i = 1'b0;
    load_req_i          = '0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    for (int t = 0; t < NR_TESTS; t++) begin
      test_start = errors;
      // 0 plain, 1 with store stalls, 2 with stalls and flushes
      match_en <= (t >= 1);
      flush_en <= (t == 2);
      for (int n = 0; n < NR_REQ / NR_TESTS; n++) begin
        issue_request();
      end
      @(posedge clk_i);
      valid_i  <= 1'b0;
      match_en <= 1'b0;
      flush_en <= 1'b0;
      drain();
      $display("test %0d done, %0d errors", t, errors - test_start);
    end
    $display("summary: %0d tests, %0d errors", NR_TESTS, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // store buffer match and flush noise
  always @(posedge clk_i) begin
    int r;
    r = $random(seed);
    page_offset_match_i <= match_en && (r[1:0] == 2'b00);
    flush_i             <= flush_en && (r[7:3] == 5'd0);
  end

  // ----------------------------------------------------------------------
  // compare process, samples at the falling edge
  // ----------------------------------------------------------------------
  always @(negedge clk_i) begin
    int         nbytes;
    be_t        exp_be;
    logic [1:0] exp_size;
    if (rst_ni) begin
      if (prev_grant) begin
        assert (dcache_req.tag_valid) else begin
          $display("tag_valid missing in the cycle after a grant");
          errors++;
        end
        assert (dcache_req.tag == prev_tag) else begin
          $display("[ERROR] dcache_req_o.tag exp %h got %h", prev_tag, dcache_req.tag);
          errors++;
        end
      end
      assert (!prev_flush || (dcache_req.kill && dcache_req.tag_valid)) else begin
        $display("kill with tag_valid not seen in the cycle after flush");
        errors++;
      end
      // store buffer sees the low address bits of the held request
      assert (!valid_i || page_offset_o == load_req_i.addr[INDEX_W-1:0]) else begin
        $display("[ERROR] page_offset_o exp %h got %h", load_req_i.addr[INDEX_W-1:0],
                 page_offset_o);
        errors++;
      end
      // index, byte enables and size of the presented request
      if (dcache_req.data_req) begin
        nbytes   = 1 << size_log2(load_req_i.op);
        exp_size = 2'(size_log2(load_req_i.op));
        exp_be   = be_t'((1 << nbytes) - 1) << load_req_i.addr[2:0];
        assert (dcache_req.index == load_req_i.addr[INDEX_W-1:0]) else begin
          $display("[ERROR] dcache_req_o.index exp %h got %h",
                   load_req_i.addr[INDEX_W-1:0], dcache_req.index);
          errors++;
        end
        assert (dcache_req.be == exp_be) else begin
          $display("[ERROR] dcache_req_o.be exp %h got %h", exp_be, dcache_req.be);
          errors++;
        end
        assert (dcache_req.size == exp_size) else begin
          $display("[ERROR] dcache_req_o.size exp %h got %h", exp_size, dcache_req.size);
          errors++;
        end
      end
      // new request while the store match stays high
      assert (!((dcache_req.data_req || pop_o) && page_offset_match_i && prev_match &&
                !prev_wait))
      else begin
        $display("data_req or pop_o raised while page offset match is high");
        errors++;
      end
      assert (!(dcache_req.data_req && outstanding >= NR_LDBUF)) else begin
        $display("data_req raised with four loads outstanding");
        errors++;
      end
      if (valid_o) begin
        assert (exp_valid[trans_id_o]) else begin
          $display("valid_o for trans_id %0d that is not expected", trans_id_o);
          errors++;
        end
        assert (result_o == exp_result[trans_id_o]) else begin
          $display("[ERROR] result_o exp %h got %h", exp_result[trans_id_o], result_o);
          errors++;
        end
        exp_valid[trans_id_o] = 1'b0;
      end
      // loads popped before the flush never retire
      if (flush_i) begin
        exp_valid = '0;
      end
      if (pop_o) begin
        exp_valid[load_req_i.trans_id]  = 1'b1;
        exp_result[load_req_i.trans_id] = expected_result(load_req_i.op, load_req_i.addr);
      end
      outstanding = outstanding + int'(dcache_req.data_req && dcache_rsp.gnt && !flush_i)
                    - int'(dcache_rsp.rvalid);
      assert (outstanding <= NR_LDBUF && outstanding >= 0) else begin
        $display("outstanding loads out of range, count %0d", outstanding);
        errors++;
      end
      prev_grant = dcache_req.data_req && dcache_rsp.gnt;
      prev_wait  = dcache_req.data_req && !dcache_rsp.gnt;
      prev_flush = flush_i;
      prev_match = page_offset_match_i;
      prev_tag   = load_req_i.addr[ADDR_W-1:INDEX_W];
    end
  end

  // watchdog sized from the request count
  initial begin
    #(NR_REQ * 40 * CLK_PERIOD);
    $display("timeout, the loads did not complete in time");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* project.f */
common/load_pkg.sv
load_buffer/load_buffer.sv
logic/load_ctrl.sv
logic/load_align.sv
logic/load_unit.sv
tests/dcache_model.sv
tests/load_unit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the load unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module load_unit_tb \
  --Mdir obj_dir -o load_unit_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/load_unit_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q -F "*** PASSED ***"; then
  exit 0
fi
exit 1
